/* design/cp0_defs.svh */
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

// Datapath widths
`define CP0_DATA_W            32
`define CP0_ADDR_W            8        // {rd, sel}
`define CP0_EXT_INT_W         6

// Register addresses, rd in [7:3] and sel in [2:0]
`define CP0_ADDR_BADVADDR     8'h40    // rd 8
`define CP0_ADDR_COUNT        8'h48    // rd 9
`define CP0_ADDR_COMPARE      8'h58    // rd 11
`define CP0_ADDR_STATUS       8'h60    // rd 12
`define CP0_ADDR_CAUSE        8'h68    // rd 13
`define CP0_ADDR_EPC          8'h70    // rd 14

// Reset values
`define CP0_COMPARE_RESET     32'hffff_ffff
`define CP0_STATUS_RESET_WORD 32'h0040_0000   // Only BEV set

`endif

/* design/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

    // Exception type as reported by the pipeline
    typedef enum logic [4:0] {
        EX_INT  = 5'd0,
        EX_ADEL = 5'd1,
        EX_ADES = 5'd2,
        EX_SYS  = 5'd3,
        EX_BP   = 5'd4,
        EX_RI   = 5'd5,
        EX_CPU  = 5'd6,
        EX_OV   = 5'd7,
        EX_TRAP = 5'd8,
        NO_EX   = 5'd31
    } exc_type_e;

    // Architectural Cause.ExcCode
    typedef enum logic [4:0] {
        CODE_INT  = 5'd0,
        CODE_ADEL = 5'd4,
        CODE_ADES = 5'd5,
        CODE_SYS  = 5'd8,
        CODE_BP   = 5'd9,
        CODE_RI   = 5'd10,
        CODE_CPU  = 5'd11,
        CODE_OV   = 5'd12,
        CODE_TRAP = 5'd13
    } exc_code_e;

    typedef struct packed {
        logic       cu0;
        logic       bev;
        logic [7:0] im;
        logic       um;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic       bd;
        logic       ti;
        logic [1:0] ce;
        logic [7:0] ip;
        exc_code_e  exc_code;
    } cause_t;

endpackage

`default_nettype wire

/* design/cp0_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

// Register write strobes from the access control
interface cp0_wr_if;
    logic [`CP0_DATA_W-1:0] wdata;    // mtc0 source operand
    logic                   status_we;
    logic                   cause_we;
    logic                   epc_we;
    logic                   count_we;
    logic                   compare_we;
    logic                   eret;     // Qualified eret, clears EXL

    modport ctrl (
        output wdata, status_we, cause_we, epc_we, count_we, compare_we, eret
    );
    modport regs (
        input  wdata, status_we, cause_we, epc_we, count_we, compare_we, eret
    );
endinterface

// Committed exception info
interface cp0_exc_if;
    logic                   ex;
    logic                   first_ex;  // ex with EXL clear
    cp0_pkg::exc_code_e     code;
    logic                   bd;
    logic [`CP0_DATA_W-1:0] pc;
    logic [`CP0_DATA_W-1:0] addr;      // ALU result, faulting data address

    modport ctrl (
        output ex, first_ex, code, bd, pc, addr
    );
    modport sink (
        input  ex, first_ex, code, bd, pc, addr
    );
endinterface

`default_nettype wire

/* design/cp0_access_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module cp0_access_ctrl (
    input  logic [4:0]              mtc0_rd,
    input  logic [2:0]              sel,
    input  logic                    valid,
    input  logic                    inst_mtc0,
    input  logic                    inst_eret,
    input  logic                    bd,
    input  logic                    ex,
    input  cp0_pkg::exc_type_e      exc_type,
    input  logic [`CP0_DATA_W-1:0]  alu_result,
    input  logic [`CP0_DATA_W-1:0]  pc,
    input  cp0_pkg::status_t        status,
    input  cp0_pkg::cause_t         cause,
    input  logic [`CP0_DATA_W-1:0]  count,
    input  logic [`CP0_DATA_W-1:0]  compare,
    input  logic [`CP0_DATA_W-1:0]  epc,
    input  logic [`CP0_DATA_W-1:0]  badvaddr,
    output logic [`CP0_DATA_W-1:0]  cp0_data,
    output logic                    eret_flush,
    cp0_wr_if.ctrl                  wr,
    cp0_exc_if.ctrl                 exc
);

    logic [`CP0_ADDR_W-1:0] addr;
    logic                   mtc0_we;

    assign addr       = {mtc0_rd, sel};
    assign mtc0_we    = valid && inst_mtc0 && !ex;   // Faulting mtc0 must not write
    assign eret_flush = valid && inst_eret && !ex;

    assign wr.wdata      = alu_result;
    assign wr.status_we  = mtc0_we && (addr == `CP0_ADDR_STATUS);
    assign wr.cause_we   = mtc0_we && (addr == `CP0_ADDR_CAUSE);
    assign wr.epc_we     = mtc0_we && (addr == `CP0_ADDR_EPC);
    assign wr.count_we   = mtc0_we && (addr == `CP0_ADDR_COUNT);
    assign wr.compare_we = mtc0_we && (addr == `CP0_ADDR_COMPARE);
    assign wr.eret       = eret_flush;

    assign exc.ex       = ex;
    assign exc.first_ex = ex && !status.exl;  // Nested exceptions keep EPC and BD
    assign exc.bd       = bd;
    assign exc.pc       = pc;
    assign exc.addr     = alu_result;

    // Pipeline exception type to ExcCode
    always_comb begin
        case (exc_type)
            cp0_pkg::EX_ADEL: exc.code = cp0_pkg::CODE_ADEL;
            cp0_pkg::EX_ADES: exc.code = cp0_pkg::CODE_ADES;
            cp0_pkg::EX_SYS:  exc.code = cp0_pkg::CODE_SYS;
            cp0_pkg::EX_BP:   exc.code = cp0_pkg::CODE_BP;
            cp0_pkg::EX_RI:   exc.code = cp0_pkg::CODE_RI;
            cp0_pkg::EX_CPU:  exc.code = cp0_pkg::CODE_CPU;
            cp0_pkg::EX_OV:   exc.code = cp0_pkg::CODE_OV;
            cp0_pkg::EX_TRAP: exc.code = cp0_pkg::CODE_TRAP;
            default:          exc.code = cp0_pkg::CODE_INT;   // EX_INT and NO_EX
        endcase
    end

    // mfc0 read mux
    always_comb begin
        case (addr)
            `CP0_ADDR_BADVADDR: cp0_data = badvaddr;
            `CP0_ADDR_COUNT:    cp0_data = count;
            `CP0_ADDR_COMPARE:  cp0_data = compare;
            `CP0_ADDR_STATUS:   cp0_data = {3'b0, status.cu0, 5'b0, status.bev, 6'b0,
                                            status.im, 3'b0, status.um, 1'b0,
                                            status.erl, status.exl, status.ie};
            `CP0_ADDR_CAUSE:    cp0_data = {cause.bd, cause.ti, cause.ce, 12'b0, cause.ip,
                                            1'b0, cause.exc_code, 2'b0};
            `CP0_ADDR_EPC:      cp0_data = epc;
            default:            cp0_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/cp0_status_cause.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module cp0_status_cause (
    input  logic                      clk,
    input  logic                      reset,
    cp0_wr_if.regs                    wr,
    cp0_exc_if.sink                   exc,
    input  logic [`CP0_EXT_INT_W-1:0] ext_int,
    input  logic                      ti,
    output cp0_pkg::status_t          status,
    output cp0_pkg::cause_t           cause
);

    localparam logic [`CP0_DATA_W-1:0] STATUS_RESET = `CP0_STATUS_RESET_WORD;

    logic               bd_q;
    logic [1:0]         ce_q;
    logic [7:0]         ip_q;
    cp0_pkg::exc_code_e exc_code_q;

    // Writable Status bits from a register word
    function automatic cp0_pkg::status_t status_from_word(logic [`CP0_DATA_W-1:0] w);
        cp0_pkg::status_t s;
        s.cu0 = w[28];
        s.bev = w[22];
        s.im  = w[15:8];
        s.um  = w[4];
        s.erl = w[2];
        s.exl = w[1];
        s.ie  = w[0];
        return s;
    endfunction

    // Status, EXL overrides below win over the mtc0 write
    always_ff @(posedge clk) begin
        if (reset) begin
            status <= status_from_word(STATUS_RESET);
        end else begin
            if (wr.status_we) begin
                status <= status_from_word(wr.wdata);
            end
            if (exc.ex) begin
                status.exl <= 1'b1;
            end else if (wr.eret) begin
                status.exl <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bd_q       <= 1'b0;
            ce_q       <= 2'b00;
            ip_q       <= 8'h00;
            exc_code_q <= cp0_pkg::CODE_INT;
        end else begin
            if (exc.first_ex) begin
                bd_q <= exc.bd;
            end
            if (exc.ex) begin
                exc_code_q <= exc.code;
            end
            if (exc.ex && exc.code == cp0_pkg::CODE_CPU) begin
                ce_q <= 2'b01;                     // Only CP1 unusable reported
            end
            // Hardware interrupts, timer shares IP7
            ip_q[7:2] <= {ext_int[`CP0_EXT_INT_W-1] | ti, ext_int[`CP0_EXT_INT_W-2:0]};
            if (wr.cause_we) begin
                ip_q[1:0] <= wr.wdata[9:8];        // Software interrupts
            end
        end
    end

    assign cause = '{bd: bd_q, ti: ti, ce: ce_q, ip: ip_q, exc_code: exc_code_q};

endmodule

`default_nettype wire

/* design/cp0_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module cp0_timer (
    input  logic                   clk,
    input  logic                   reset,
    cp0_wr_if.regs                 wr,
    output logic [`CP0_DATA_W-1:0] count,
    output logic [`CP0_DATA_W-1:0] compare,
    output logic                   ti
);

    logic tick;   // Half-rate enable for Count

    always_ff @(posedge clk) begin
        if (reset) begin
            tick    <= 1'b0;
            count   <= '0;
            compare <= `CP0_COMPARE_RESET;
            ti      <= 1'b0;
        end else begin
            tick <= ~tick;
            if (wr.count_we) begin
                count <= wr.wdata;                 // Write beats the increment
            end else if (tick) begin
                count <= count + 32'd1;
            end
            if (wr.compare_we) begin
                compare <= wr.wdata;
            end
            if (wr.compare_we) begin
                ti <= 1'b0;                        // Compare write acknowledges the interrupt
            end else if (count == compare) begin
                ti <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/cp0_exc_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module cp0_exc_capture (
    input  logic                   clk,
    input  logic                   reset,
    cp0_wr_if.regs                 wr,
    cp0_exc_if.sink                exc,
    output logic [`CP0_DATA_W-1:0] epc,
    output logic [`CP0_DATA_W-1:0] badvaddr
);

    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (exc.first_ex) begin
            // In a delay slot point back at the branch
            epc <= exc.bd ? exc.pc - 32'd4 : exc.pc;
        end else if (wr.epc_we) begin
            epc <= wr.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badvaddr <= '0;
        end else if (exc.ex) begin
            if (exc.code == cp0_pkg::CODE_ADES) begin
                badvaddr <= exc.addr;
            end else if (exc.code == cp0_pkg::CODE_ADEL) begin
                // Misaligned fetch reports pc, else the load address
                badvaddr <= (exc.pc[1:0] != 2'b00) ? exc.pc : exc.addr;
            end
        end
    end

endmodule

`default_nettype wire

/* design/cp0_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module cp0_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [4:0]                mtc0_rd,
    input  logic [2:0]                sel,
    input  logic                      valid,
    input  logic                      inst_mtc0,
    input  logic                      inst_eret,
    input  logic                      bd,
    input  logic                      ex,
    input  logic [4:0]                exc_type,
    input  logic [`CP0_DATA_W-1:0]    alu_result,
    input  logic [`CP0_DATA_W-1:0]    pc,
    input  logic [`CP0_EXT_INT_W-1:0] ext_int,
    output logic [`CP0_DATA_W-1:0]    cp0_data,
    output logic                      eret_flush,
    output logic [`CP0_DATA_W-1:0]    epc_out,
    output logic                      status_ie,
    output logic                      status_exl,
    output logic [7:0]                status_im,
    output logic [7:0]                cause_ip,
    output logic                      cause_ti
);

    cp0_pkg::status_t       status;
    cp0_pkg::cause_t        cause;
    logic                   ti;
    logic [`CP0_DATA_W-1:0] count;
    logic [`CP0_DATA_W-1:0] compare;
    logic [`CP0_DATA_W-1:0] badvaddr;

    cp0_wr_if  u_wr ();
    cp0_exc_if u_exc ();

    cp0_access_ctrl u_access_ctrl (
        .mtc0_rd    (mtc0_rd),
        .sel        (sel),
        .valid      (valid),
        .inst_mtc0  (inst_mtc0),
        .inst_eret  (inst_eret),
        .bd         (bd),
        .ex         (ex),
        .exc_type   (cp0_pkg::exc_type_e'(exc_type)),
        .alu_result (alu_result),
        .pc         (pc),
        .status     (status),
        .cause      (cause),
        .count      (count),
        .compare    (compare),
        .epc        (epc_out),
        .badvaddr   (badvaddr),
        .cp0_data   (cp0_data),
        .eret_flush (eret_flush),
        .wr         (u_wr),
        .exc        (u_exc)
    );

    cp0_status_cause u_status_cause (
        .clk     (clk),
        .reset   (reset),
        .wr      (u_wr),
        .exc     (u_exc),
        .ext_int (ext_int),
        .ti      (ti),
        .status  (status),
        .cause   (cause)
    );

    cp0_timer u_timer (
        .clk     (clk),
        .reset   (reset),
        .wr      (u_wr),
        .count   (count),
        .compare (compare),
        .ti      (ti)
    );

    cp0_exc_capture u_exc_capture (
        .clk      (clk),
        .reset    (reset),
        .wr       (u_wr),
        .exc      (u_exc),
        .epc      (epc_out),
        .badvaddr (badvaddr)
    );

    // Field taps for the pipeline
    assign status_ie  = status.ie;
    assign status_exl = status.exl;
    assign status_im  = status.im;
    assign cause_ip   = cause.ip;
    assign cause_ti   = cause.ti;

endmodule

`default_nettype wire

/* dv/cp0_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_checker #(
    parameter int HALF_PERIOD = 50,
    parameter int SKEW        = 5
) (
    input  logic        clk,
    input  logic [7:0]  mask,          // {im, data, flush, epc, exl, ie, ip, ti}
    input  logic [31:0] exp_data,
    input  logic [31:0] exp_epc,
    input  logic [3:0]  exp_flags,     // {flush, exl, ie, ti}
    input  logic [7:0]  exp_ip,
    input  logic [7:0]  exp_im,
    input  logic [31:0] cp0_data,
    input  logic        eret_flush,
    input  logic [31:0] epc_out,
    input  logic        status_exl,
    input  logic        status_ie,
    input  logic [7:0]  status_im,
    input  logic [7:0]  cause_ip,
    input  logic        cause_ti,
    output int          error_count,
    output int          check_count
);

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Sample just before the rising edge
    always @(negedge clk) begin
        #(HALF_PERIOD - SKEW);
        if (mask[7]) compare_value("status_im", 32'(exp_im), 32'(status_im));
        if (mask[6]) compare_value("cp0_data", exp_data, cp0_data);
        if (mask[5]) compare_value("eret_flush", 32'(exp_flags[3]), 32'(eret_flush));
        if (mask[4]) compare_value("epc_out", exp_epc, epc_out);
        if (mask[3]) compare_value("status_exl", 32'(exp_flags[2]), 32'(status_exl));
        if (mask[2]) compare_value("status_ie", 32'(exp_flags[1]), 32'(status_ie));
        if (mask[1]) compare_value("cause_ip", 32'(exp_ip), 32'(cause_ip));
        if (mask[0]) compare_value("cause_ti", 32'(exp_flags[0]), 32'(cause_ti));
    end

endmodule

`default_nettype wire

/* dv/cp0_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cp0_defs.svh"

module cp0_tb;

    localparam int HALF_PERIOD = 50;

    // Control field {valid, mtc0, eret, bd, ex, exc_type}
    localparam logic [9:0] NOP    = {5'b00000, cp0_pkg::NO_EX};
    localparam logic [9:0] RD     = {5'b10000, cp0_pkg::NO_EX};
    localparam logic [9:0] WR     = {5'b11000, cp0_pkg::NO_EX};
    localparam logic [9:0] WR_NV  = {5'b01000, cp0_pkg::NO_EX};   // mtc0 without valid
    localparam logic [9:0] WR_X   = {5'b11001, cp0_pkg::EX_OV};   // mtc0 that faults
    localparam logic [9:0] ERT    = {5'b10100, cp0_pkg::NO_EX};
    localparam logic [9:0] ERT_X  = {5'b10101, cp0_pkg::EX_OV};
    localparam logic [9:0] X_SYS  = {5'b10001, cp0_pkg::EX_SYS};
    localparam logic [9:0] X_OV   = {5'b10001, cp0_pkg::EX_OV};
    localparam logic [9:0] X_ADEL = {5'b10001, cp0_pkg::EX_ADEL};
    localparam logic [9:0] X_ADES = {5'b10001, cp0_pkg::EX_ADES};
    localparam logic [9:0] BDS    = 10'h040;

    localparam logic [7:0] A_ST  = `CP0_ADDR_STATUS;
    localparam logic [7:0] A_CA  = `CP0_ADDR_CAUSE;
    localparam logic [7:0] A_EPC = `CP0_ADDR_EPC;
    localparam logic [7:0] A_CNT = `CP0_ADDR_COUNT;
    localparam logic [7:0] A_CMP = `CP0_ADDR_COMPARE;
    localparam logic [7:0] A_BAD = `CP0_ADDR_BADVADDR;

    localparam logic [7:0] M_IM    = 8'h80;
    localparam logic [7:0] M_DATA  = 8'h40;
    localparam logic [7:0] M_FLUSH = 8'h20;
    localparam logic [7:0] M_EPC   = 8'h10;
    localparam logic [7:0] M_EXL   = 8'h08;
    localparam logic [7:0] M_IE    = 8'h04;
    localparam logic [7:0] M_IP    = 8'h02;
    localparam logic [7:0] M_TI    = 8'h01;

    typedef struct packed {
        logic [9:0]  ctl;
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic [31:0] pc;
        logic [5:0]  ext;
        logic [7:0]  idle;     // Idle cycles before the row
        logic [7:0]  mask;
        logic [31:0] e_data;
        logic [31:0] e_epc;
        logic [3:0]  e_flags;
        logic [7:0]  e_ip;
    } row_t;

    logic        clk = 1'b0;
    logic        reset;
    logic [4:0]  mtc0_rd;
    logic [2:0]  sel;
    logic        valid;
    logic        inst_mtc0;
    logic        inst_eret;
    logic        bd;
    logic        ex;
    logic [4:0]  exc_type;
    logic [31:0] alu_result;
    logic [31:0] pc;
    logic [5:0]  ext_int;
    logic [31:0] cp0_data;
    logic        eret_flush;
    logic [31:0] epc_out;
    logic        status_ie;
    logic        status_exl;
    logic [7:0]  status_im;
    logic [7:0]  cause_ip;
    logic        cause_ti;
    logic [7:0]  chk_mask;
    logic [31:0] exp_data;
    logic [31:0] exp_epc;
    logic [3:0]  exp_flags;
    logic [7:0]  exp_ip;
    logic [7:0]  exp_im;
    int          error_count;
    int          check_count;

    row_t   rows[$];
    integer seed         = 32'hcad0;
    int     total_cycles = 0;
    int     cycle_limit  = 0;
    int     cycles       = 0;

    always #(HALF_PERIOD) clk = ~clk;

    cp0_top u_cp0_top (
        .clk        (clk),
        .reset      (reset),
        .mtc0_rd    (mtc0_rd),
        .sel        (sel),
        .valid      (valid),
        .inst_mtc0  (inst_mtc0),
        .inst_eret  (inst_eret),
        .bd         (bd),
        .ex         (ex),
        .exc_type   (exc_type),
        .alu_result (alu_result),
        .pc         (pc),
        .ext_int    (ext_int),
        .cp0_data   (cp0_data),
        .eret_flush (eret_flush),
        .epc_out    (epc_out),
        .status_ie  (status_ie),
        .status_exl (status_exl),
        .status_im  (status_im),
        .cause_ip   (cause_ip),
        .cause_ti   (cause_ti)
    );

    cp0_checker #(.HALF_PERIOD(HALF_PERIOD)) u_checker (
        .clk         (clk),
        .mask        (chk_mask),
        .exp_data    (exp_data),
        .exp_epc     (exp_epc),
        .exp_flags   (exp_flags),
        .exp_ip      (exp_ip),
        .exp_im      (exp_im),
        .cp0_data    (cp0_data),
        .eret_flush  (eret_flush),
        .epc_out     (epc_out),
        .status_exl  (status_exl),
        .status_ie   (status_ie),
        .status_im   (status_im),
        .cause_ip    (cause_ip),
        .cause_ti    (cause_ti),
        .error_count (error_count),
        .check_count (check_count)
    );

    task automatic add_row(input logic [9:0] ctl, input logic [7:0] addr,
                           input logic [31:0] wdata, input logic [31:0] pc_v,
                           input logic [5:0] ext, input logic [7:0] idle,
                           input logic [7:0] mask, input logic [31:0] e_data,
                           input logic [31:0] e_epc, input logic [3:0] e_flags,
                           input logic [7:0] e_ip);
        rows.push_back('{ctl, addr, wdata, pc_v, ext, idle, mask, e_data, e_epc, e_flags, e_ip});
        total_cycles += int'(idle) + 1;
    endtask

    task automatic apply_row(input row_t r);
        repeat (r.idle) begin
            @(negedge clk);
            {valid, inst_mtc0, inst_eret, bd, ex, exc_type} = NOP;
            ext_int  = r.ext;
            chk_mask = '0;
        end
        @(negedge clk);
        {valid, inst_mtc0, inst_eret, bd, ex, exc_type} = r.ctl;
        {mtc0_rd, sel} = r.addr;
        alu_result = r.wdata;
        pc         = r.pc;
        ext_int    = r.ext;
        chk_mask   = r.mask;
        exp_data   = r.e_data;
        exp_epc    = r.e_epc;
        exp_flags  = r.e_flags;
        exp_ip     = r.e_ip;
        exp_im     = r.e_data[15:8];   // IM field of the expected Status word
    endtask

    // Flags column is {flush, exl, ie, ti}
    task automatic build_table();
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] w;
        logic [31:0] p1;
        logic [31:0] p2;
        logic [31:0] p3;
        logic [31:0] p4;
        logic [31:0] p5;
        logic [31:0] p6;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        d1 = $random(seed);
        d2 = $random(seed);
        w  = $random(seed);
        p1 = $random(seed) & 32'hffff_fffc;
        p2 = $random(seed) & 32'hffff_fffc;
        p3 = $random(seed) & 32'hffff_fffc;
        p4 = $random(seed) | 32'h0000_0001;   // Misaligned fetch
        p5 = $random(seed) & 32'hffff_fffc;
        p6 = $random(seed) | 32'h0000_0002;
        a1 = $random(seed);
        a2 = $random(seed);
        a3 = $random(seed);
        // Reset values
        add_row(RD, A_ST, '0, '0, '0, '0, M_DATA | M_FLUSH | M_EXL | M_IE | M_TI | M_IP | M_IM,
                32'h0040_0000, '0, 4'b0000, 8'h00);
        add_row(RD, A_CA, '0, '0, '0, '0, M_DATA, 32'h0000_0000, '0, 4'b0000, 8'h00);
        add_row(RD, A_CMP, '0, '0, '0, '0, M_DATA, 32'hffff_ffff, '0, 4'b0000, 8'h00);
        add_row(RD, A_EPC, '0, '0, '0, '0, M_DATA | M_EPC, '0, '0, 4'b0000, 8'h00);
        // mtc0 and mfc0 round trips
        add_row(WR, A_ST, 32'hffff_ffff, '0, '0, '0, M_FLUSH | M_EXL, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_ST, '0, '0, '0, '0, M_DATA | M_EXL | M_IE | M_IM, 32'h1040_ff17, '0,
                4'b0110, 8'h00);
        add_row(WR, A_ST, '0, '0, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_ST, '0, '0, '0, '0, M_DATA | M_EXL | M_IE | M_IM, '0, '0, 4'b0000, 8'h00);
        add_row(WR, A_EPC, d1, '0, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_EPC, '0, '0, '0, '0, M_DATA | M_EPC, d1, d1, 4'b0000, 8'h00);
        add_row(WR_NV, A_EPC, d2, '0, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_EPC, '0, '0, '0, '0, M_DATA | M_EPC, d1, d1, 4'b0000, 8'h00);
        add_row(WR, A_CA, 32'hffff_ffff, '0, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_CA, '0, '0, '0, '0, M_DATA | M_IP, 32'h0000_0300, '0, 4'b0000, 8'h03);
        add_row(WR, A_CA, '0, '0, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_CA, '0, '0, '0, '0, M_DATA | M_IP, '0, '0, 4'b0000, 8'h00);
        // Only the first exception captures EPC
        add_row(X_SYS, A_ST, '0, p1, '0, '0, M_FLUSH | M_EXL, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_EPC, '0, '0, '0, '0, M_DATA | M_EPC | M_EXL, p1, p1, 4'b0100, 8'h00);
        add_row(RD, A_CA, '0, '0, '0, '0, M_DATA, 32'h0000_0020, '0, 4'b0100, 8'h00);
        add_row(X_OV, A_ST, '0, p2, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_EPC, '0, '0, '0, '0, M_EPC, '0, p1, 4'b0100, 8'h00);
        add_row(RD, A_CA, '0, '0, '0, '0, M_DATA, 32'h0000_0030, '0, 4'b0100, 8'h00);
        add_row(WR_X, A_EPC, d2, p2, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_EPC, '0, '0, '0, '0, M_DATA, p1, '0, 4'b0000, 8'h00);
        add_row(ERT_X, A_ST, '0, p2, '0, '0, M_FLUSH | M_EXL, '0, '0, 4'b0100, 8'h00);
        add_row(RD, A_ST, '0, '0, '0, '0, M_FLUSH | M_EXL, '0, '0, 4'b0100, 8'h00);
        add_row(ERT, A_ST, '0, '0, '0, '0, M_FLUSH | M_EXL, '0, '0, 4'b1100, 8'h00);
        add_row(RD, A_ST, '0, '0, '0, '0, M_DATA | M_EXL, '0, '0, 4'b0000, 8'h00);
        // Delay slot and bad addresses
        add_row(X_SYS | BDS, A_ST, '0, p3, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_EPC, '0, '0, '0, '0, M_DATA | M_EPC | M_EXL, p3 - 32'd4, p3 - 32'd4,
                4'b0100, 8'h00);
        add_row(RD, A_CA, '0, '0, '0, '0, M_DATA, 32'h8000_0020, '0, 4'b0100, 8'h00);
        add_row(X_ADEL, A_ST, a1, p4, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_BAD, '0, '0, '0, '0, M_DATA | M_EPC, p4, p3 - 32'd4, 4'b0000, 8'h00);
        add_row(X_ADEL, A_ST, a2, p5, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_BAD, '0, '0, '0, '0, M_DATA, a2, '0, 4'b0000, 8'h00);
        add_row(X_ADES, A_ST, a3, p6, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_BAD, '0, '0, '0, '0, M_DATA, a3, '0, 4'b0000, 8'h00);
        add_row(ERT, A_ST, '0, '0, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        // External interrupts land one cycle late
        add_row(RD, A_CA, '0, '0, 6'b101101, '0, M_IP, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_CA, '0, '0, 6'b101101, '0, M_IP, '0, '0, 4'b0000, 8'hb4);
        add_row(RD, A_CA, '0, '0, 6'b000000, '0, M_IP, '0, '0, 4'b0000, 8'hb4);
        add_row(RD, A_CA, '0, '0, 6'b000000, '0, M_IP, '0, '0, 4'b0000, 8'h00);
        // Timer interrupt and Count rate
        add_row(WR, A_CNT, '0, '0, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(WR, A_CMP, 32'd10, '0, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_CMP, '0, '0, '0, 8'd24, M_DATA | M_TI | M_IP, 32'd10, '0, 4'b0001, 8'h80);
        add_row(WR, A_CMP, 32'hffff_ffff, '0, '0, '0, M_TI, '0, '0, 4'b0001, 8'h00);
        add_row(RD, A_CMP, '0, '0, '0, '0, M_DATA | M_TI, 32'hffff_ffff, '0, 4'b0000, 8'h00);
        add_row(WR, A_CNT, w, '0, '0, '0, '0, '0, '0, 4'b0000, 8'h00);
        add_row(RD, A_CNT, '0, '0, '0, 8'd10, M_DATA, w + 32'd5, '0, 4'b0000, 8'h00);
        add_row(RD, A_CNT, '0, '0, '0, 8'd19, M_DATA, w + 32'd15, '0, 4'b0000, 8'h00);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        reset      = 1'b1;
        {valid, inst_mtc0, inst_eret, bd, ex, exc_type} = NOP;
        {mtc0_rd, sel} = '0;
        alu_result = '0;
        pc         = '0;
        ext_int    = '0;
        chk_mask   = '0;
        exp_data   = '0;
        exp_epc    = '0;
        exp_flags  = '0;
        exp_ip     = '0;
        exp_im     = '0;
        build_table();
        cycle_limit = total_cycles + 4 + 50;   // Rows, reset and margin
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (rows[i]) apply_row(rows[i]);
        @(posedge clk);                        // Last check samples before this edge
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+design
design/cp0_pkg.sv
design/cp0_if.sv
design/cp0_access_ctrl.sv
design/cp0_status_cause.sv
design/cp0_timer.sv
design/cp0_exc_capture.sv
design/cp0_top.sv
dv/cp0_checker.sv
dv/cp0_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the CP0 testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module cp0_tb -o cp0_sim > build.log 2>&1 &&
./obj_dir/cp0_sim > sim.log 2>&1 &&
! grep -q "TESTBENCH FAILED" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
